/* hw/vga_pkg.sv */
package vga_pkg;

    // horizontal line timing in pixel clocks, 640x480 at 60 Hz
    localparam int h_active     = 640;
    localparam int h_sync_start = 656;
    localparam int h_sync_end   = 752; // exclusive
    localparam int h_total      = 800;

    // vertical frame timing in lines
    localparam int v_active     = 480;
    localparam int v_sync_start = 490;
    localparam int v_sync_end   = 492; // exclusive
    localparam int v_total      = 525;

    // centered 320x240 window that is fed from the frame buffer
    localparam int win_x0 = 160;
    localparam int win_x1 = 480; // exclusive
    localparam int win_y0 = 120;
    localparam int win_y1 = 360; // exclusive

    localparam int win_pixels = (win_x1 - win_x0) * (win_y1 - win_y0);

    // 17 bits covers the 76800 window words
    localparam int fb_addr_w = 17;

    // both beam counters fit in 10 bits
    localparam int count_w = 10;

    // beam counters to pins: one cycle of RAM read, one cycle of output register
    localparam int pipe_delay = 2;

    // one RGB565 word
    // the writer and the RAM only move it around as raw bits
    // scan-out is the one place that splits it into color fields
    typedef union packed {
        logic [15:0] raw;
        struct packed {
            logic [4:0] red;   // bits 15:11
            logic [5:0] green; // bits 10:5
            logic [4:0] blue;  // bits 4:0
        } rgb;
    } pixel_word_u;

endpackage

/* hw/raster_timing.sv */
module raster_timing (
    input  logic                        clk_25m,
    input  logic                        rst_n,
    output logic [vga_pkg::count_w-1:0] h_count,
    output logic [vga_pkg::count_w-1:0] v_count,
    output logic                        hsync,
    output logic                        vsync
);
    import vga_pkg::*;

    logic             h_last;
    logic             v_last;
    logic             hs_now;
    logic             vs_now;
    logic [pipe_delay-1:0] hs_pipe;
    logic [pipe_delay-1:0] vs_pipe;

    assign h_last = (h_count == count_w'(h_total - 1));
    assign v_last = (v_count == count_w'(v_total - 1));

    // beam position, the first cycle after reset is (0, 0)
    always_ff @(posedge clk_25m or negedge rst_n) begin
        if (!rst_n) begin
            h_count <= '0;
            v_count <= '0;
        end else if (h_last) begin
            h_count <= '0;
            if (v_last) begin
                v_count <= '0;
            end else begin
                v_count <= v_count + 1'b1;
            end
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    // sync windows as seen by the current beam position
    assign hs_now = (h_count >= count_w'(h_sync_start)) && (h_count < count_w'(h_sync_end));
    assign vs_now = (v_count >= count_w'(v_sync_start)) && (v_count < count_w'(v_sync_end));

    // the sync flags ride the same number of stages as the color path
    // so a pulse lines up with the pixel data it belongs to
    always_ff @(posedge clk_25m or negedge rst_n) begin
        if (!rst_n) begin
            hs_pipe <= '0;
            vs_pipe <= '0;
        end else begin
            hs_pipe <= {hs_pipe[pipe_delay-2:0], hs_now};
            vs_pipe <= {vs_pipe[pipe_delay-2:0], vs_now};
        end
    end

    // both pulses are active low, so a cleared pipe leaves them high
    assign hsync = ~hs_pipe[pipe_delay-1];
    assign vsync = ~vs_pipe[pipe_delay-1];

    // the wrap compare must catch every line and frame end
    a_count_range: assert property (
        @(posedge clk_25m) disable iff (!rst_n)
        (h_count < count_w'(h_total)) && (v_count < count_w'(v_total))
    ) else $error("raster counter out of range h=%0d v=%0d", h_count, v_count);

endmodule

/* hw/window_scanout.sv */
module window_scanout (
    input  logic                          clk_25m,
    input  logic                          rst_n,
    input  logic [vga_pkg::count_w-1:0]   h_count,
    input  logic [vga_pkg::count_w-1:0]   v_count,
    output logic [vga_pkg::fb_addr_w-1:0] rd_addr,
    input  vga_pkg::pixel_word_u          rd_data,
    output logic [4:0]                    vga_red,
    output logic [5:0]                    vga_green,
    output logic [4:0]                    vga_blue
);
    import vga_pkg::*;

    logic                 row_in;
    logic                 col_in;
    logic                 in_win;
    logic                 in_win_d1; // lines up with rd_data
    logic [fb_addr_w-1:0] addr_q;

    assign row_in = (v_count >= count_w'(win_y0)) && (v_count < count_w'(win_y1));
    assign col_in = (h_count >= count_w'(win_x0)) && (h_count < count_w'(win_x1));
    assign in_win = row_in && col_in;

    // the window is stored row after row, so the address simply counts
    // window pixels and starts over outside the window rows
    always_ff @(posedge clk_25m or negedge rst_n) begin
        if (!rst_n) begin
            addr_q <= '0;
        end else if (!row_in) begin
            addr_q <= '0;
        end else if (in_win) begin
            if (addr_q == fb_addr_w'(win_pixels - 1)) begin
                addr_q <= '0; // last pixel of the window
            end else begin
                addr_q <= addr_q + 1'b1;
            end
        end
    end

    assign rd_addr = addr_q;

    always_ff @(posedge clk_25m or negedge rst_n) begin
        if (!rst_n) begin
            in_win_d1 <= 1'b0;
            vga_red   <= '0;
            vga_green <= '0;
            vga_blue  <= '0;
        end else begin
            in_win_d1 <= in_win;
            if (in_win_d1) begin
                vga_red   <= rd_data.rgb.red;
                vga_green <= rd_data.rgb.green;
                vga_blue  <= rd_data.rgb.blue;
            end else begin
                vga_red   <= '0; // border stays black
                vga_green <= '0;
                vga_blue  <= '0;
            end
        end
    end

    a_addr_range: assert property (
        @(posedge clk_25m) disable iff (!rst_n)
        rd_addr < fb_addr_w'(win_pixels)
    ) else $error("scan-out read address %0d past end of window", rd_addr);

endmodule

/* hw/frame_buffer.sv */
module frame_buffer (
    input  logic                          clk_25m,
    input  logic                          wr_en,
    input  logic [vga_pkg::fb_addr_w-1:0] wr_addr,
    input  vga_pkg::pixel_word_u          wr_data,
    input  logic [vga_pkg::fb_addr_w-1:0] rd_addr,
    output vga_pkg::pixel_word_u          rd_data
);
    import vga_pkg::*;

    // one word per window pixel, row r column c lives at r*320 + c
    pixel_word_u mem [win_pixels];

    // write and read share one process, so a read that hits the word
    // being written in the same cycle still returns the old contents
    always_ff @(posedge clk_25m) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr]; // one cycle read latency
    end

endmodule

/* hw/pixel_writer.sv */
module pixel_writer (
    input  logic                          clk_25m,
    input  logic                          rst_n,
    input  logic                          wr_start,
    input  logic                          wr_valid,
    input  vga_pkg::pixel_word_u          wr_pixel,
    output logic                          wr_en,
    output logic [vga_pkg::fb_addr_w-1:0] wr_addr,
    output vga_pkg::pixel_word_u          wr_data
);
    import vga_pkg::*;

    logic [fb_addr_w-1:0] wr_ptr;
    logic [fb_addr_w-1:0] cur_addr;
    logic [fb_addr_w-1:0] next_addr;

    // a start pulse takes effect in its own cycle, so a strobe that
    // comes with it lands on word 0
    assign cur_addr  = wr_start ? '0 : wr_ptr;
    assign next_addr = (cur_addr == fb_addr_w'(win_pixels - 1)) ? '0 : cur_addr + 1'b1;

    always_ff @(posedge clk_25m or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            wr_en  <= 1'b0;
        end else begin
            wr_en <= wr_valid;
            if (wr_valid) begin
                wr_ptr <= next_addr;
            end else if (wr_start) begin
                wr_ptr <= '0;
            end
        end
    end

    always_ff @(posedge clk_25m) begin
        wr_addr <= cur_addr;
        wr_data <= wr_pixel;
    end

    // wrap handling must hold across any mix of start pulses and strobes
    a_ptr_range: assert property (
        @(posedge clk_25m) disable iff (!rst_n)
        wr_ptr < fb_addr_w'(win_pixels)
    ) else $error("write pointer %0d past end of window", wr_ptr);

endmodule

/* hw/vga_display_top.sv */
module vga_display_top (
    input  logic                 clk_25m,
    input  logic                 rst_n,
    input  logic                 wr_start,
    input  logic                 wr_valid,
    input  vga_pkg::pixel_word_u wr_pixel,
    output logic [4:0]           vga_red,
    output logic [5:0]           vga_green,
    output logic [4:0]           vga_blue,
    output logic                 vga_hsync,
    output logic                 vga_vsync
);
    import vga_pkg::*;

    logic [count_w-1:0]   h_count;
    logic [count_w-1:0]   v_count;
    logic [fb_addr_w-1:0] rd_addr;
    pixel_word_u          rd_data;
    logic                 wr_en;
    logic [fb_addr_w-1:0] wr_addr;
    pixel_word_u          wr_data;

    raster_timing raster_timing_i (
        .clk_25m (clk_25m),
        .rst_n   (rst_n),
        .h_count (h_count),
        .v_count (v_count),
        .hsync   (vga_hsync),
        .vsync   (vga_vsync)
    );

    window_scanout window_scanout_i (
        .clk_25m   (clk_25m),
        .rst_n     (rst_n),
        .h_count   (h_count),
        .v_count   (v_count),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .vga_red   (vga_red),
        .vga_green (vga_green),
        .vga_blue  (vga_blue)
    );

    frame_buffer frame_buffer_i (
        .clk_25m (clk_25m),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // host side, shares the pixel clock
    pixel_writer pixel_writer_i (
        .clk_25m  (clk_25m),
        .rst_n    (rst_n),
        .wr_start (wr_start),
        .wr_valid (wr_valid),
        .wr_pixel (wr_pixel),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

endmodule

/* testbench/tb_vga_display.sv */
module tb_vga_display;
    timeunit 1ns;
    timeprecision 100ps;
    import vga_pkg::*;

    localparam int frame_cycles = h_total * v_total;
    localparam int wait_limit   = 500000; // longest gap between two waits is well below this
    localparam int num_probes   = 16;

    logic        clk_25m;
    logic        rst_n;
    logic        wr_start;
    logic        wr_valid;
    pixel_word_u wr_pixel;
    logic [4:0]  vga_red;
    logic [5:0]  vga_green;
    logic [4:0]  vga_blue;
    logic        vga_hsync;
    logic        vga_vsync;

    int unsigned cyc;
    int          err_count;
    int          timeout_count;
    int          check_count;
    int          seed;
    logic [31:0] fill_seed;
    logic [15:0] exp_mem [win_pixels]; // what the frame buffer should hold
    int unsigned model_ptr;

    // probes run in time order from the frame 0 corners and border to the frame 1 rewrite
    int probe_x [num_probes] = '{0, 300, 160, 479, 159, 480, 160, 479, 300,
                                 160, 161, 162, 163, 164, 165, 479};
    int probe_y [num_probes] = '{0, 119, 120, 120, 200, 200, 359, 359, 360,
                                 120, 120, 120, 120, 120, 120, 359};
    int probe_f [num_probes] = '{0, 0, 0, 0, 0, 0, 0, 0, 0,
                                 1, 1, 1, 1, 1, 1, 1};

    // words 3 and 4 keep the burst values while the wrap hits words 0 to 2 again
    logic [15:0] burst_words [5] = '{16'h1357, 16'h2468, 16'h9ABC, 16'hF800, 16'h07E0};
    logic [15:0] wrap_words [3]  = '{16'h001F, 16'hC3A5, 16'h5A3C};

    vga_display_top dut_i (
        .clk_25m   (clk_25m),
        .rst_n     (rst_n),
        .wr_start  (wr_start),
        .wr_valid  (wr_valid),
        .wr_pixel  (wr_pixel),
        .vga_red   (vga_red),
        .vga_green (vga_green),
        .vga_blue  (vga_blue),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync)
    );

    always #20 clk_25m = ~clk_25m;

    // cycle 0 is the first clock period after reset release
    always @(posedge clk_25m) begin
        if (rst_n) begin
            cyc <= cyc + 1;
        end
    end

    function automatic logic [15:0] fill_value(input int unsigned addr);
        logic [31:0] mix;
        mix = addr * 32'h9E37_79B1 + fill_seed; // odd multiplier spreads every address bit
        return mix[31:16] ^ mix[15:0];
    endfunction

    // returns at the falling edge inside the target cycle, where outputs are settled
    task automatic wait_cycle(input int unsigned target, output bit reached);
        int unsigned spins;
        spins = 0;
        @(negedge clk_25m);
        while (cyc != target && spins < wait_limit) begin
            @(negedge clk_25m);
            spins++;
        end
        reached = (cyc == target);
        if (!reached) begin
            $display("Timeout: cycle %0d was never reached, gave up at cycle %0d", target, cyc);
            timeout_count++;
        end
    endtask

    // called at drive time, leaves the caller at drive time of the next cycle
    task automatic drive_strobe(input logic start, input logic valid, input logic [15:0] value);
        wr_start     = start;
        wr_valid     = valid;
        wr_pixel.raw = value;
        if (start) begin
            model_ptr = 0;
        end
        if (valid) begin
            exp_mem[model_ptr] = value;
            model_ptr = (model_ptr == win_pixels - 1) ? 0 : model_ptr + 1;
        end
        @(posedge clk_25m);
        #2;
    endtask

    initial begin
        clk_25m       = 1'b0;
        rst_n         = 1'b0;
        wr_start      = 1'b0;
        wr_valid      = 1'b0;
        wr_pixel      = '0;
        cyc           = 0;
        err_count     = 0;
        timeout_count = 0;
        check_count   = 0;
        model_ptr     = 0;
        seed          = 32'h8777;
        fill_seed     = $random(seed);

        repeat (8) @(posedge clk_25m);
        #1;
        check_count++;
        if ({vga_red, vga_green, vga_blue} !== 16'h0 ||
            vga_hsync !== 1'b1 || vga_vsync !== 1'b1) begin
            $display("Mismatch outputs in reset: rgb %h hsync %h vsync %h",
                     {vga_red, vga_green, vga_blue}, vga_hsync, vga_vsync);
            err_count++;
        end
        #1;
        rst_n = 1'b1;

        fork
            begin : host_writes
                bit          ok;
                int unsigned addr;
                // the frame 0 load is done long before row 120 is scanned
                for (int a = 0; a < win_pixels; a++) begin
                    drive_strobe(a == 0, 1'b1, fill_value(a));
                end
                drive_strobe(1'b0, 1'b0, 16'h0);
                wait_cycle(frame_cycles, ok);
                @(posedge clk_25m);
                #2;
                for (int i = 0; i < 5; i++) begin
                    drive_strobe(i == 0, 1'b1, burst_words[i]);
                end
                // 76803 strobes after the restart leave the pointer at word 3
                for (int i = 0; i < win_pixels - 2; i++) begin
                    addr = (5 + i) % win_pixels;
                    drive_strobe(1'b0, 1'b1, (addr < 3) ? wrap_words[addr] : fill_value(addr));
                end
                drive_strobe(1'b0, 1'b0, 16'h0);
            end

            begin : probe_loop
                int unsigned target;
                int          x;
                int          y;
                int          addr;
                logic [15:0] expect_word;
                bit          ok;
                for (int c = 0; c < pipe_delay; c++) begin
                    wait_cycle(c, ok);
                    if (ok) begin
                        check_count++;
                        if ({vga_red, vga_green, vga_blue} !== 16'h0) begin
                            $display("Mismatch rgb in cycle %0d: got %h expected 0000",
                                     c, {vga_red, vga_green, vga_blue});
                            err_count++;
                        end
                    end
                end
                for (int i = 0; i < num_probes; i++) begin
                    x      = probe_x[i];
                    y      = probe_y[i];
                    target = probe_f[i] * frame_cycles + y * h_total + x + pipe_delay;
                    wait_cycle(target, ok);
                    if (ok) begin
                        expect_word = 16'h0; // black border
                        if (x >= win_x0 && x < win_x1 && y >= win_y0 && y < win_y1) begin
                            addr        = (y - win_y0) * (win_x1 - win_x0) + (x - win_x0);
                            expect_word = exp_mem[addr];
                        end
                        check_count += 3;
                        if (vga_red !== expect_word[15:11]) begin
                            $display("Mismatch vga_red at (%0d,%0d) frame %0d: got %h expected %h",
                                     x, y, probe_f[i], vga_red, expect_word[15:11]);
                            err_count++;
                        end
                        if (vga_green !== expect_word[10:5]) begin
                            $display("Mismatch vga_green at (%0d,%0d) frame %0d: got %h expected %h",
                                     x, y, probe_f[i], vga_green, expect_word[10:5]);
                            err_count++;
                        end
                        if (vga_blue !== expect_word[4:0]) begin
                            $display("Mismatch vga_blue at (%0d,%0d) frame %0d: got %h expected %h",
                                     x, y, probe_f[i], vga_blue, expect_word[4:0]);
                            err_count++;
                        end
                    end
                end
            end

            begin : sync_checks
                int unsigned target;
                int unsigned vs_cycle [4];
                logic        vs_level [4];
                logic        expect_hs;
                bit          ok;
                // every cycle of line 10 is seen two cycles late at the pins
                for (int h = 0; h < h_total; h++) begin
                    target    = 10 * h_total + h + pipe_delay;
                    expect_hs = !(h >= h_sync_start && h < h_sync_end);
                    wait_cycle(target, ok);
                    if (ok) begin
                        check_count++;
                        if (vga_hsync !== expect_hs) begin
                            $display("Mismatch vga_hsync at h=%0d: got %h expected %h",
                                     h, vga_hsync, expect_hs);
                            err_count++;
                        end
                    end
                end
                vs_cycle[0] = v_sync_start * h_total + pipe_delay - 1;
                vs_level[0] = 1'b1;
                vs_cycle[1] = v_sync_start * h_total + pipe_delay;
                vs_level[1] = 1'b0;
                vs_cycle[2] = v_sync_end * h_total + pipe_delay - 1;
                vs_level[2] = 1'b0;
                vs_cycle[3] = v_sync_end * h_total + pipe_delay;
                vs_level[3] = 1'b1;
                for (int k = 0; k < 4; k++) begin
                    wait_cycle(vs_cycle[k], ok);
                    if (ok) begin
                        check_count++;
                        if (vga_vsync !== vs_level[k]) begin
                            $display("Mismatch vga_vsync in cycle %0d: got %h expected %h",
                                     vs_cycle[k], vga_vsync, vs_level[k]);
                            err_count++;
                        end
                    end
                end
            end
        join

        $display("checks %0d, mismatches %0d, timeouts %0d",
                 check_count, err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0 && check_count > 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
hw/vga_pkg.sv
hw/raster_timing.sv
hw/window_scanout.sv
hw/frame_buffer.sv
hw/pixel_writer.sv
hw/vga_display_top.sv
testbench/tb_vga_display.sv

/* Bender.yml */
package:
  name: vga_display

sources:
  # package first, the RTL modules import it
  - files:
      - hw/vga_pkg.sv
      - hw/raster_timing.sv
      - hw/window_scanout.sv
      - hw/frame_buffer.sv
      - hw/pixel_writer.sv
      - hw/vga_display_top.sv

  - target: test
    files:
      - testbench/tb_vga_display.sv
